/* frog_defs.svh */
`ifndef FROG_DEFS_SVH
`define FROG_DEFS_SVH

// Matrix is square, rows and columns share this size
`define FROG_ROWS 8
`define FROG_START_COL 4

// Game limits
`define FROG_LIVES 3
`define FROG_LEVELS 4

// Clock cycles between two obstacle steps
`define FROG_STEP_CYCLES 64

`endif

/* frog_pkg.sv */
`default_nettype none

`include "frog_defs.svh"

package frog_pkg;

	typedef logic [`FROG_ROWS-1:0] row_t;
	typedef logic [$clog2(`FROG_ROWS)-1:0] coord_t;
	typedef logic [$clog2(`FROG_LIVES+1)-1:0] lives_t;
	typedef logic [$clog2(`FROG_LEVELS)-1:0] level_t;

	typedef enum logic [2:0] {
		PHASE_IDLE,
		PHASE_PLAY,
		PHASE_LEVEL_DONE,
		PHASE_WON,
		PHASE_LOST
	} game_phase_t;

endpackage

`default_nettype wire

/* level_patterns.sv */
`default_nettype none

`include "frog_defs.svh"

module level_patterns (
	input wire frog_pkg::level_t level,
	output frog_pkg::row_t pattern_rows [`FROG_ROWS]
);

	// Rows listed bottom first, start and goal rows stay clear
	always_comb begin
		case (level)
			2'd0: pattern_rows = '{
				8'b00000000, 8'b00000000, 8'b11001100, 8'b00000000,
				8'b00100100, 8'b10001000, 8'b00000000, 8'b00000000
			};
			2'd1: pattern_rows = '{
				8'b00000000, 8'b00000000, 8'b11100110, 8'b00010000,
				8'b10000010, 8'b00000000, 8'b01000100, 8'b00000000
			};
			2'd2: pattern_rows = '{
				8'b00000000, 8'b00100000, 8'b11001100, 8'b00000000,
				8'b01100101, 8'b10000001, 8'b10110010, 8'b00000000
			};
			// Densest field for the last level
			default: pattern_rows = '{
				8'b00000000, 8'b00000010, 8'b11001100, 8'b00000101,
				8'b01100100, 8'b00001100, 8'b01110001, 8'b00000000
			};
		endcase
	end

endmodule

`default_nettype wire

/* obstacle_field.sv */
`default_nettype none

`include "frog_defs.svh"

module obstacle_field (
	input wire logic clock_50,
	input wire logic rst,
	input wire logic playing,
	input wire logic load_level,
	input wire frog_pkg::level_t level,
	output frog_pkg::row_t field_rows [`FROG_ROWS]
);

	localparam int CNT_W = $clog2(`FROG_STEP_CYCLES);
	localparam int STEP_LAST = `FROG_STEP_CYCLES - 1;

	frog_pkg::level_t pattern_level;
	frog_pkg::row_t pattern_rows [`FROG_ROWS];
	logic [CNT_W-1:0] step_cnt;
	logic step;

	// ====================
	// Level table
	// ====================

	// Reset always brings back the first level
	assign pattern_level = rst ? frog_pkg::level_t'(0) : level;

	level_patterns u_level_patterns (
		.level(pattern_level),
		.pattern_rows(pattern_rows)
	);

	// ====================
	// Step prescaler
	// ====================

	assign step = playing && (step_cnt == STEP_LAST[CNT_W-1:0]);

	always_ff @(posedge clock_50) begin
		if (rst || load_level) begin
			step_cnt <= '0;
		end else if (playing) begin
			if (step) begin
				step_cnt <= '0;
			end else begin
				step_cnt <= step_cnt + 1'b1;
			end
		end
	end

	// ====================
	// Row registers
	// ====================

	// Even rows drift left, odd rows drift right
	always_ff @(posedge clock_50) begin
		if (rst || load_level) begin
			field_rows <= pattern_rows;
		end else if (step) begin
			for (int r = 0; r < `FROG_ROWS; r++) begin
				if (r % 2 == 0) begin
					field_rows[r] <= {field_rows[r][`FROG_ROWS-2:0], field_rows[r][`FROG_ROWS-1]};
				end else begin
					field_rows[r] <= {field_rows[r][0], field_rows[r][`FROG_ROWS-1:1]};
				end
			end
		end
	end

endmodule

`default_nettype wire

/* frog_control.sv */
`default_nettype none

`include "frog_defs.svh"

module frog_control (
	input wire logic clock_50,
	input wire logic rst,
	input wire logic playing,
	input wire logic frog_reset,
	input wire logic up_button,
	input wire logic down_button,
	input wire logic left_button,
	input wire logic right_button,
	output frog_pkg::coord_t frog_row,
	output frog_pkg::coord_t frog_col
);

	localparam frog_pkg::coord_t LAST = frog_pkg::coord_t'(`FROG_ROWS - 1);
	localparam frog_pkg::coord_t START_COL = frog_pkg::coord_t'(`FROG_START_COL);

	logic up_prev;
	logic down_prev;
	logic left_prev;
	logic right_prev;
	logic up_edge;
	logic down_edge;
	logic left_edge;
	logic right_edge;

	// Button levels from the previous edge
	always_ff @(posedge clock_50) begin
		if (rst) begin
			up_prev <= 1'b0;
			down_prev <= 1'b0;
			left_prev <= 1'b0;
			right_prev <= 1'b0;
		end else begin
			up_prev <= up_button;
			down_prev <= down_button;
			left_prev <= left_button;
			right_prev <= right_button;
		end
	end

	assign up_edge = up_button && !up_prev;
	assign down_edge = down_button && !down_prev;
	assign left_edge = left_button && !left_prev;
	assign right_edge = right_button && !right_prev;

	// One move per edge, up wins over down, down over left, left over right
	always_ff @(posedge clock_50) begin
		if (rst || frog_reset) begin
			frog_row <= '0;
			frog_col <= START_COL;
		end else if (playing) begin
			if (up_edge) begin
				if (frog_row != LAST) frog_row <= frog_row + 1'b1;
			end else if (down_edge) begin
				if (frog_row != '0) frog_row <= frog_row - 1'b1;
			end else if (left_edge) begin
				if (frog_col != '0) frog_col <= frog_col - 1'b1;
			end else if (right_edge) begin
				if (frog_col != LAST) frog_col <= frog_col + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* game_control.sv */
`default_nettype none

`include "frog_defs.svh"

module game_control (
	input wire logic clock_50,
	input wire logic rst,
	input wire logic start_button,
	input wire logic collision,
	input wire frog_pkg::coord_t frog_row,
	output logic playing,
	output logic frog_reset,
	output logic load_level,
	output frog_pkg::level_t level,
	output frog_pkg::lives_t lives,
	output frog_pkg::game_phase_t phase
);

	localparam frog_pkg::coord_t GOAL_ROW = frog_pkg::coord_t'(`FROG_ROWS - 1);
	localparam frog_pkg::lives_t FULL_LIVES = frog_pkg::lives_t'(`FROG_LIVES);
	localparam frog_pkg::level_t LAST_LEVEL = frog_pkg::level_t'(`FROG_LEVELS - 1);

	logic start_prev;
	logic start_edge;
	logic goal;
	frog_pkg::game_phase_t phase_next;
	frog_pkg::lives_t lives_next;
	frog_pkg::level_t level_q;
	frog_pkg::level_t level_next;

	assign start_edge = start_button && !start_prev;
	assign goal = (frog_row == GOAL_ROW);
	assign playing = (phase == frog_pkg::PHASE_PLAY);

	// During a load pulse the field must already see the level being loaded
	assign level = level_next;

	// ====================
	// Phase FSM
	// ====================
	always_comb begin
		phase_next = phase;
		lives_next = lives;
		level_next = level_q;
		frog_reset = 1'b0;
		load_level = 1'b0;
		case (phase)
			frog_pkg::PHASE_IDLE: begin
				if (start_edge) phase_next = frog_pkg::PHASE_PLAY;
			end
			frog_pkg::PHASE_PLAY: begin
				if (collision) begin
					frog_reset = 1'b1;
					lives_next = lives - 1'b1;
					// Last life gone
					if (lives == frog_pkg::lives_t'(1)) phase_next = frog_pkg::PHASE_LOST;
				end else if (goal) begin
					frog_reset = 1'b1;
					if (level_q == LAST_LEVEL) begin
						phase_next = frog_pkg::PHASE_WON;
					end else begin
						phase_next = frog_pkg::PHASE_LEVEL_DONE;
					end
				end
			end
			frog_pkg::PHASE_LEVEL_DONE: begin
				if (start_edge) begin
					level_next = level_q + 1'b1;
					load_level = 1'b1;
					phase_next = frog_pkg::PHASE_PLAY;
				end
			end
			frog_pkg::PHASE_WON, frog_pkg::PHASE_LOST: begin
				// Fresh game from the first level
				if (start_edge) begin
					level_next = '0;
					lives_next = FULL_LIVES;
					load_level = 1'b1;
					frog_reset = 1'b1;
					phase_next = frog_pkg::PHASE_PLAY;
				end
			end
			default: phase_next = frog_pkg::PHASE_IDLE;
		endcase
	end

	always_ff @(posedge clock_50) begin
		if (rst) begin
			phase <= frog_pkg::PHASE_IDLE;
			lives <= FULL_LIVES;
			level_q <= '0;
			start_prev <= 1'b0;
		end else begin
			phase <= phase_next;
			lives <= lives_next;
			level_q <= level_next;
			start_prev <= start_button;
		end
	end

endmodule

`default_nettype wire

/* frame_compose.sv */
`default_nettype none

`include "frog_defs.svh"

module frame_compose (
	input wire frog_pkg::game_phase_t phase,
	input wire frog_pkg::row_t field_rows [`FROG_ROWS],
	input wire frog_pkg::coord_t frog_row,
	input wire frog_pkg::coord_t frog_col,
	input wire frog_pkg::coord_t column_addr,
	output logic collision,
	output frog_pkg::row_t column_data
);

	localparam frog_pkg::coord_t LAST = frog_pkg::coord_t'(`FROG_ROWS - 1);

	// ====================
	// End screens, row 0 first
	// ====================
	localparam frog_pkg::row_t NEXT_SCREEN [`FROG_ROWS] = '{
		8'b00001000, 8'b00000100, 8'b00000010, 8'b11111111,
		8'b11111111, 8'b00000010, 8'b00000100, 8'b00001000
	};
	localparam frog_pkg::row_t WON_SCREEN [`FROG_ROWS] = '{
		8'b00000000, 8'b00000000, 8'b01111110, 8'b01111110,
		8'b00000000, 8'b01100110, 8'b01100110, 8'b00000000
	};
	localparam frog_pkg::row_t LOSE_SCREEN [`FROG_ROWS] = '{
		8'b01000010, 8'b01000010, 8'b00111100, 8'b00000000,
		8'b10011001, 8'b01100110, 8'b01100110, 8'b10011001
	};

	frog_pkg::row_t frog_bit;
	frog_pkg::row_t hit_rows;
	frog_pkg::row_t frame_rows [`FROG_ROWS];

	// Column c lives in bit 7-c of a row
	assign frog_bit = frog_pkg::row_t'({1'b1, {(`FROG_ROWS-1){1'b0}}}) >> frog_col;

	always_comb begin
		for (int r = 0; r < `FROG_ROWS; r++) begin
			if (frog_pkg::coord_t'(r) == frog_row) begin
				hit_rows[r] = |(field_rows[r] & frog_bit);
				frame_rows[r] = field_rows[r] | frog_bit;
			end else begin
				hit_rows[r] = 1'b0;
				frame_rows[r] = field_rows[r];
			end
		end
		case (phase)
			frog_pkg::PHASE_LEVEL_DONE: frame_rows = NEXT_SCREEN;
			frog_pkg::PHASE_WON: frame_rows = WON_SCREEN;
			frog_pkg::PHASE_LOST: frame_rows = LOSE_SCREEN;
			default: ;
		endcase
	end

	assign collision = (phase == frog_pkg::PHASE_PLAY) && |hit_rows;

	// Column scan, row 0 lands on the top bit
	always_comb begin
		for (int r = 0; r < `FROG_ROWS; r++) begin
			column_data[`FROG_ROWS-1-r] = frame_rows[r][LAST - column_addr];
		end
	end

endmodule

`default_nettype wire

/* frogger_top.sv */
`default_nettype none

`include "frog_defs.svh"

module frogger_top (
	input wire logic clock_50,
	input wire logic rst,
	input wire logic start_button,
	input wire logic up_button,
	input wire logic down_button,
	input wire logic left_button,
	input wire logic right_button,
	input wire frog_pkg::coord_t column_addr,
	output frog_pkg::row_t column_data,
	output frog_pkg::lives_t lives,
	output frog_pkg::level_t level,
	output frog_pkg::game_phase_t phase
);

	logic playing;
	logic frog_reset;
	logic load_level;
	logic collision;
	frog_pkg::row_t field_rows [`FROG_ROWS];
	frog_pkg::coord_t frog_row;
	frog_pkg::coord_t frog_col;

	game_control u_game_control (
		.clock_50(clock_50),
		.rst(rst),
		.start_button(start_button),
		.collision(collision),
		.frog_row(frog_row),
		.playing(playing),
		.frog_reset(frog_reset),
		.load_level(load_level),
		.level(level),
		.lives(lives),
		.phase(phase)
	);

	frog_control u_frog_control (
		.clock_50(clock_50),
		.rst(rst),
		.playing(playing),
		.frog_reset(frog_reset),
		.up_button(up_button),
		.down_button(down_button),
		.left_button(left_button),
		.right_button(right_button),
		.frog_row(frog_row),
		.frog_col(frog_col)
	);

	obstacle_field u_obstacle_field (
		.clock_50(clock_50),
		.rst(rst),
		.playing(playing),
		.load_level(load_level),
		.level(level),
		.field_rows(field_rows)
	);

	frame_compose u_frame_compose (
		.phase(phase),
		.field_rows(field_rows),
		.frog_row(frog_row),
		.frog_col(frog_col),
		.column_addr(column_addr),
		.collision(collision),
		.column_data(column_data)
	);

endmodule

`default_nettype wire

/* frogger_tb.sv */
`default_nettype none

`include "frog_defs.svh"

module frogger_tb;

	localparam int LAST = `FROG_ROWS - 1;
	localparam int STEP_LAST = `FROG_STEP_CYCLES - 1;
	localparam int BTN_NONE = 0;
	localparam int BTN_UP = 1;
	localparam int BTN_DOWN = 2;
	localparam int BTN_LEFT = 3;
	localparam int BTN_RIGHT = 4;
	localparam int BTN_START = 5;

	// Level tables with row 0 first in each level
	localparam logic [7:0] LEVEL_TAB [32] = '{
		8'h00, 8'h00, 8'hcc, 8'h00, 8'h24, 8'h88, 8'h00, 8'h00,
		8'h00, 8'h00, 8'he6, 8'h10, 8'h82, 8'h00, 8'h44, 8'h00,
		8'h00, 8'h20, 8'hcc, 8'h00, 8'h65, 8'h81, 8'hb2, 8'h00,
		8'h00, 8'h02, 8'hcc, 8'h05, 8'h64, 8'h0c, 8'h71, 8'h00
	};
	localparam logic [7:0] NEXT_TAB [8] = '{8'h08, 8'h04, 8'h02, 8'hff, 8'hff, 8'h02, 8'h04, 8'h08};
	localparam logic [7:0] WON_TAB [8] = '{8'h00, 8'h00, 8'h7e, 8'h7e, 8'h00, 8'h66, 8'h66, 8'h00};
	localparam logic [7:0] LOSE_TAB [8] = '{8'h42, 8'h42, 8'h3c, 8'h00, 8'h99, 8'h66, 8'h66, 8'h99};

	logic clock_50;
	logic rst;
	logic start_button;
	logic up_button;
	logic down_button;
	logic left_button;
	logic right_button;
	frog_pkg::coord_t column_addr;
	frog_pkg::row_t column_data;
	frog_pkg::lives_t lives;
	frog_pkg::level_t level;
	frog_pkg::game_phase_t phase;

	// Reference model state
	frog_pkg::game_phase_t m_phase;
	int m_lives;
	int m_level;
	int m_row;
	int m_col;
	int m_cnt;
	logic [7:0] m_field [8];
	logic [4:0] m_prev;

	frogger_top UUT (
		.clock_50(clock_50),
		.rst(rst),
		.start_button(start_button),
		.up_button(up_button),
		.down_button(down_button),
		.left_button(left_button),
		.right_button(right_button),
		.column_addr(column_addr),
		.column_data(column_data),
		.lives(lives),
		.level(level),
		.phase(phase)
	);

	initial begin
		clock_50 = 1'b0;
		forever #10 clock_50 = ~clock_50;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	// Watchdog for the whole run
	initial begin
		repeat (400000) @(posedge clock_50);
		fail_run("timeout: the run did not finish in time");
	end

	// No lives left only ever shows together with the lose screen
	assert property (@(posedge clock_50) disable iff (rst)
		(lives != 0) || (phase == frog_pkg::PHASE_LOST))
		else fail_run("lives reached zero outside the lost phase");

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		assert (got == exp)
			else fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	function automatic logic [7:0] rotate_row(input int r, input logic [7:0] x);
		if (r % 2 == 0) return {x[6:0], x[7]};
		return {x[0], x[7:1]};
	endfunction

	function automatic logic [7:0] frame_row(input int r);
		case (m_phase)
			frog_pkg::PHASE_LEVEL_DONE: return NEXT_TAB[r];
			frog_pkg::PHASE_WON: return WON_TAB[r];
			frog_pkg::PHASE_LOST: return LOSE_TAB[r];
			default: return m_field[r] | ((r == m_row) ? (8'h80 >> m_col) : 8'h00);
		endcase
	endfunction

	function automatic logic cell_free(input int r, input int c, input logic stepped);
		logic [7:0] x;
		x = stepped ? rotate_row(r, m_field[r]) : m_field[r];
		return !x[LAST - c];
	endfunction

	// Checks outputs and drives inputs for one cycle, then advances the model
	task automatic run_cycle(input int btn);
		logic [4:0] b;
		logic [4:0] e;
		logic [7:0] exp;
		logic [7:0] row_val;
		logic coll;
		logic frst;
		logic load;
		frog_pkg::game_phase_t n_phase;
		int n_lives;
		int n_level;
		check_value("phase", 8'(phase), 8'(m_phase));
		check_value("lives", 8'(lives), 8'(m_lives));
		check_value("level", 8'(level), 8'(m_level));
		// Bits are start, up, down, left, right
		b = '0;
		if (btn == BTN_START) b[4] = 1'b1;
		if (btn == BTN_UP) b[3] = 1'b1;
		if (btn == BTN_DOWN) b[2] = 1'b1;
		if (btn == BTN_LEFT) b[1] = 1'b1;
		if (btn == BTN_RIGHT) b[0] = 1'b1;
		{start_button, up_button, down_button, left_button, right_button} = b;
		for (int c = 0; c < 8; c++) begin
			column_addr = 3'(c);
			#1;
			for (int r = 0; r < 8; r++) begin
				row_val = frame_row(r);
				exp[LAST - r] = row_val[LAST - c];
			end
			check_value("column_data", column_data, exp);
		end
		e = b & ~m_prev;
		coll = (m_phase == frog_pkg::PHASE_PLAY) && !cell_free(m_row, m_col, 1'b0);
		n_phase = m_phase;
		n_lives = m_lives;
		n_level = m_level;
		frst = 1'b0;
		load = 1'b0;
		case (m_phase)
			frog_pkg::PHASE_IDLE: if (e[4]) n_phase = frog_pkg::PHASE_PLAY;
			frog_pkg::PHASE_PLAY: begin
				if (coll) begin
					frst = 1'b1;
					n_lives = m_lives - 1;
					if (m_lives == 1) n_phase = frog_pkg::PHASE_LOST;
				end else if (m_row == LAST) begin
					frst = 1'b1;
					n_phase = (m_level == `FROG_LEVELS - 1) ? frog_pkg::PHASE_WON
						: frog_pkg::PHASE_LEVEL_DONE;
				end
			end
			frog_pkg::PHASE_LEVEL_DONE: begin
				if (e[4]) begin
					n_level = m_level + 1;
					load = 1'b1;
					n_phase = frog_pkg::PHASE_PLAY;
				end
			end
			default: begin
				if (e[4]) begin
					n_level = 0;
					n_lives = `FROG_LIVES;
					load = 1'b1;
					frst = 1'b1;
					n_phase = frog_pkg::PHASE_PLAY;
				end
			end
		endcase
		@(posedge clock_50);
		if (frst) begin
			m_row = 0;
			m_col = `FROG_START_COL;
		end else if (m_phase == frog_pkg::PHASE_PLAY) begin
			if (e[3]) begin
				if (m_row != LAST) m_row++;
			end else if (e[2]) begin
				if (m_row != 0) m_row--;
			end else if (e[1]) begin
				if (m_col != 0) m_col--;
			end else if (e[0]) begin
				if (m_col != LAST) m_col++;
			end
		end
		if (load) begin
			for (int r = 0; r < 8; r++) m_field[r] = LEVEL_TAB[n_level * 8 + r];
			m_cnt = 0;
		end else if (m_phase == frog_pkg::PHASE_PLAY) begin
			if (m_cnt == STEP_LAST) begin
				for (int r = 0; r < 8; r++) m_field[r] = rotate_row(r, m_field[r]);
				m_cnt = 0;
			end else begin
				m_cnt++;
			end
		end
		m_phase = n_phase;
		m_lives = n_lives;
		m_level = n_level;
		m_prev = b;
		@(negedge clock_50);
	endtask

	// Press for one cycle and release for one
	task automatic play_turn(input int btn);
		run_cycle(btn);
		run_cycle(BTN_NONE);
	endtask

	function automatic int side_step();
		return ($urandom % 2 == 0) ? BTN_LEFT : BTN_RIGHT;
	endfunction

	// Picks a move that keeps the frog clear of the next obstacle step
	function automatic int careful_move();
		logic near;
		near = (m_cnt >= STEP_LAST - 3);
		if (m_row < LAST && cell_free(m_row + 1, m_col, 1'b0) && cell_free(m_row + 1, m_col, 1'b1))
			return BTN_UP;
		if (near && !cell_free(m_row, m_col, 1'b1)) begin
			if (m_col > 0 && cell_free(m_row, m_col - 1, 1'b0) && cell_free(m_row, m_col - 1, 1'b1))
				return BTN_LEFT;
			if (m_col < LAST && cell_free(m_row, m_col + 1, 1'b0)
					&& cell_free(m_row, m_col + 1, 1'b1))
				return BTN_RIGHT;
		end
		if (m_row == 0 && $urandom % 4 == 0) return side_step();
		return BTN_NONE;
	endfunction

	initial begin
		int guard;
		int btn;
		void'($urandom(32'hd5e8));
		rst = 1'b1;
		{start_button, up_button, down_button, left_button, right_button} = '0;
		column_addr = '0;
		m_phase = frog_pkg::PHASE_IDLE;
		m_lives = `FROG_LIVES;
		m_level = 0;
		m_row = 0;
		m_col = `FROG_START_COL;
		m_cnt = 0;
		m_prev = '0;
		for (int r = 0; r < 8; r++) m_field[r] = LEVEL_TAB[r];
		repeat (8) @(posedge clock_50);
		@(negedge clock_50);
		rst = 1'b0;

		// Idle field must stay frozen
		repeat (100) run_cycle(BTN_NONE);
		play_turn(BTN_START);

		// Moves, borders and a held button
		repeat (6) play_turn(BTN_LEFT);
		play_turn(BTN_DOWN);
		repeat (4) run_cycle(BTN_RIGHT);
		run_cycle(BTN_NONE);
		repeat (8) play_turn(BTN_RIGHT);
		repeat (3) play_turn(BTN_LEFT);

		// Rotation over several steps in the empty start row
		repeat (3 * `FROG_STEP_CYCLES) run_cycle(BTN_NONE);

		// Walk into obstacles until every life is gone
		guard = 0;
		while (m_phase == frog_pkg::PHASE_PLAY) begin
			guard++;
			if (guard > 3000) fail_run("timeout: frog never lost its lives");
			if (m_row < LAST && (!cell_free(m_row + 1, m_col, m_cnt == STEP_LAST)
					|| m_field[m_row + 1] == 8'h00))
				btn = BTN_UP;
			else
				btn = side_step();
			play_turn(btn);
		end
		if (m_phase != frog_pkg::PHASE_LOST) fail_run("game left play without losing");
		repeat (4) run_cycle(BTN_NONE);
		play_turn(BTN_START);
		check_value("phase", 8'(phase), 8'(frog_pkg::PHASE_PLAY));
		check_value("lives", 8'(lives), 8'(`FROG_LIVES));
		check_value("level", 8'(level), 8'h00);

		// Play through every level
		guard = 0;
		while (m_phase != frog_pkg::PHASE_WON) begin
			guard++;
			if (guard > 60000) fail_run("timeout: game was never won");
			if (m_phase == frog_pkg::PHASE_PLAY) play_turn(careful_move());
			else play_turn(BTN_START);
		end
		repeat (4) run_cycle(BTN_NONE);
		play_turn(BTN_START);
		check_value("phase", 8'(phase), 8'(frog_pkg::PHASE_PLAY));
		check_value("lives", 8'(lives), 8'(`FROG_LIVES));
		check_value("level", 8'(level), 8'h00);
		repeat (4) run_cycle(BTN_NONE);

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
frog_pkg.sv
level_patterns.sv
obstacle_field.sv
frog_control.sv
game_control.sv
frame_compose.sv
frogger_top.sv
frogger_tb.sv

/* Makefile */
SRCS := $(wildcard *.sv *.svh)

.PHONY: run clean

obj_dir/Vfrogger_tb: verilog.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module frogger_tb -f verilog.f

run: obj_dir/Vfrogger_tb
	./obj_dir/Vfrogger_tb | tee /dev/stderr | grep -q "Regression passed"

clean:
	rm -rf obj_dir
